// File: flist.f
+incdir+rtl
rtl/mmu_pkg.sv
rtl/mmu_miss_buffer.sv
rtl/mmu_lru.sv
rtl/mmu_wait_timer.sv
rtl/mmu_fsm.sv
rtl/mmu_top.sv
test/mmu_asserts.sv
test/mmu_checker.sv
test/tb_mmu.sv

// File: rtl/mmu_defs.svh
`ifndef MMU_DEFS_SVH
`define MMU_DEFS_SVH

// Byte address width
`define MMU_ADDR_W 32

// Line geometry, shared by both caches
`define MMU_LINE_BYTES 16
`define MMU_OFFSET_W 4

// Set count and index width
`define MMU_SETS 8
`define MMU_INDEX_W 3

// Associativity
`define MMU_WAYS 4
`define MMU_WAY_W 2

// Cycles to wait for a memory ack before aborting
`define MMU_TIMEOUT 24

`endif

// File: rtl/mmu_fsm.sv
`timescale 1ns/100ps
`include "mmu_defs.svh"

module mmu_fsm (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            dc_pending_i,
    input  logic            ic_pending_i,
    input  mmu_pkg::addr_t  dc_addr_i,
    input  mmu_pkg::addr_t  ic_addr_i,
    input  logic            mm_ack_i,
    input  logic            expired_i,
    output logic            mm_req_o,
    output mmu_pkg::addr_t  mm_addr_o,
    output mmu_pkg::src_e   sel_o,
    output logic            deliver_dc_o,
    output logic            deliver_ic_o,
    output logic            err_o,
    output logic            timer_start_o,
    output logic            timer_clear_o,
    output logic            lru_fill_o,
    output mmu_pkg::index_t lru_index_o
);

    mmu_pkg::mmu_state_e state_q;
    mmu_pkg::mmu_state_e state_d;
    mmu_pkg::src_e       sel_q;
    mmu_pkg::src_e       sel_d;
    logic                mm_req_q;
    logic                err_q;
    mmu_pkg::addr_t      mm_addr_q;
    mmu_pkg::addr_t      sel_addr;
    logic                other_pending;

    assign sel_addr      = (sel_q == mmu_pkg::DCACHE) ? dc_addr_i : ic_addr_i;
    assign other_pending = (sel_q == mmu_pkg::DCACHE) ? ic_pending_i : dc_pending_i;

    always_comb begin
        state_d = state_q;
        sel_d   = sel_q;
        case (state_q)
            mmu_pkg::IDLE: begin
                // D-cache wins a tie
                if (dc_pending_i) begin
                    state_d = mmu_pkg::MM_REQ;
                    sel_d   = mmu_pkg::DCACHE;
                end else if (ic_pending_i) begin
                    state_d = mmu_pkg::MM_REQ;
                    sel_d   = mmu_pkg::ICACHE;
                end
            end
            mmu_pkg::MM_REQ: begin
                state_d = mmu_pkg::MM_WAIT;
            end
            mmu_pkg::MM_WAIT: begin
                if (mm_ack_i || expired_i) begin
                    state_d = mmu_pkg::DELIVER;
                end
            end
            mmu_pkg::DELIVER: begin
                state_d = mmu_pkg::MM_RELEASE;
            end
            mmu_pkg::MM_RELEASE: begin
                // Memory must be idle again before the next request
                if (!mm_ack_i) begin
                    if (other_pending) begin
                        state_d = mmu_pkg::MM_REQ;
                        sel_d   = (sel_q == mmu_pkg::DCACHE) ? mmu_pkg::ICACHE : mmu_pkg::DCACHE;
                    end else begin
                        state_d = mmu_pkg::IDLE;
                    end
                end
            end
            default: begin
                state_d = mmu_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q  <= mmu_pkg::IDLE;
            sel_q    <= mmu_pkg::DCACHE;
            mm_req_q <= 1'b0;
            err_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            sel_q   <= sel_d;
            if (state_q == mmu_pkg::MM_REQ) begin
                mm_req_q <= 1'b1;
            end else if (state_q == mmu_pkg::MM_WAIT) begin
                if (mm_ack_i) begin
                    err_q <= 1'b0;
                end else if (expired_i) begin
                    // Abort, no ack has been seen yet
                    mm_req_q <= 1'b0;
                    err_q    <= 1'b1;
                end
            end else if (state_q == mmu_pkg::DELIVER) begin
                mm_req_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == mmu_pkg::MM_REQ) begin
            mm_addr_q <= sel_addr;
        end
    end

    assign mm_req_o      = mm_req_q;
    assign mm_addr_o     = mm_addr_q;
    assign sel_o         = sel_q;
    assign err_o         = err_q;
    assign deliver_dc_o  = (state_q == mmu_pkg::DELIVER) && (sel_q == mmu_pkg::DCACHE);
    assign deliver_ic_o  = (state_q == mmu_pkg::DELIVER) && (sel_q == mmu_pkg::ICACHE);
    assign lru_fill_o    = (state_q == mmu_pkg::DELIVER);
    assign timer_start_o = (state_q == mmu_pkg::MM_REQ);
    assign timer_clear_o = (state_q == mmu_pkg::DELIVER);
    assign lru_index_o   = sel_addr[`MMU_OFFSET_W +: `MMU_INDEX_W];

endmodule : mmu_fsm

// File: rtl/mmu_lru.sv
`timescale 1ns/100ps
`include "mmu_defs.svh"

module mmu_lru (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  mmu_pkg::hit_t   dc_hit_i,
    input  mmu_pkg::hit_t   ic_hit_i,
    input  logic            fill_i,
    input  mmu_pkg::src_e   fill_src_i,
    input  mmu_pkg::index_t fill_index_i,
    output mmu_pkg::way_t   dc_victim_o,
    output mmu_pkg::way_t   ic_victim_o
);

    localparam int WAYS    = `MMU_WAYS;
    localparam int ORDER_W = WAYS * (WAYS - 1) / 2;

    // Bit (i,j) with i<j is set while way i is older than way j
    logic [ORDER_W-1:0] dc_order [`MMU_SETS];
    logic [ORDER_W-1:0] ic_order [`MMU_SETS];

    function automatic int pair_bit(input int lo, input int hi);
        return lo * WAYS - (lo * (lo + 1)) / 2 + (hi - lo - 1);
    endfunction

    function automatic mmu_pkg::way_t lru_way(input logic [ORDER_W-1:0] ord);
        mmu_pkg::way_t way;
        logic          oldest;
        way = '0;
        for (int i = 0; i < WAYS; i++) begin
            oldest = 1'b1;
            for (int j = 0; j < WAYS; j++) begin
                if (j > i) begin
                    if (!ord[pair_bit(i, j)]) oldest = 1'b0;
                end else if (j < i) begin
                    if (ord[pair_bit(j, i)]) oldest = 1'b0;
                end
            end
            if (oldest) way = mmu_pkg::way_t'(i);
        end
        return way;
    endfunction

    // Make one way the most recent of its set
    function automatic logic [ORDER_W-1:0] touch(input logic [ORDER_W-1:0] ord,
                                                 input mmu_pkg::way_t way);
        logic [ORDER_W-1:0] upd;
        upd = ord;
        for (int k = 0; k < WAYS; k++) begin
            if (k > int'(way)) upd[pair_bit(int'(way), k)] = 1'b0;
            else if (k < int'(way)) upd[pair_bit(k, int'(way))] = 1'b1;
        end
        return upd;
    endfunction

    // Hit first, fill last
    function automatic logic [ORDER_W-1:0] next_order(input logic [ORDER_W-1:0] ord,
                                                      input mmu_pkg::index_t set,
                                                      input mmu_pkg::hit_t hit,
                                                      input logic fill,
                                                      input mmu_pkg::way_t fill_way);
        logic [ORDER_W-1:0] upd;
        upd = ord;
        if (hit.valid && hit.index == set) upd = touch(upd, hit.way);
        if (fill && fill_index_i == set) upd = touch(upd, fill_way);
        return upd;
    endfunction

    assign dc_victim_o = lru_way(dc_order[fill_index_i]);
    assign ic_victim_o = lru_way(ic_order[fill_index_i]);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int s = 0; s < `MMU_SETS; s++) begin
                dc_order[s] <= '1;
                ic_order[s] <= '1;
            end
        end else begin
            for (int s = 0; s < `MMU_SETS; s++) begin
                dc_order[s] <= next_order(dc_order[s], mmu_pkg::index_t'(s), dc_hit_i,
                                          fill_i && fill_src_i == mmu_pkg::DCACHE, dc_victim_o);
                ic_order[s] <= next_order(ic_order[s], mmu_pkg::index_t'(s), ic_hit_i,
                                          fill_i && fill_src_i == mmu_pkg::ICACHE, ic_victim_o);
            end
        end
    end

endmodule : mmu_lru

// File: rtl/mmu_miss_buffer.sv
`timescale 1ns/100ps
`include "mmu_defs.svh"

module mmu_miss_buffer (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            miss_req_i,
    input  mmu_pkg::addr_t  miss_addr_i,
    input  logic            deliver_i,
    input  logic            err_i,
    input  mmu_pkg::line_t  data_i,
    input  mmu_pkg::way_t   way_i,
    output logic            miss_ack_o,
    output mmu_pkg::fill_t  fill_o,
    output logic            pending_o,
    output mmu_pkg::addr_t  line_addr_o
);

    logic           full_q;
    logic           pending_q;
    logic           ack_q;
    logic           capture;
    mmu_pkg::addr_t line_addr_q;
    mmu_pkg::fill_t fill_q;

    // Only take a new miss once the previous handshake has fully closed
    assign capture = miss_req_i && !full_q && !ack_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            full_q    <= 1'b0;
            pending_q <= 1'b0;
            ack_q     <= 1'b0;
        end else if (deliver_i) begin
            full_q    <= 1'b0;
            pending_q <= 1'b0;
            ack_q     <= 1'b1;
        end else begin
            if (capture) begin
                full_q <= 1'b1;
            end
            // Pending follows the captured flag one cycle behind
            pending_q <= full_q;
            if (!miss_req_i) begin
                ack_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture) begin
            line_addr_q <= {miss_addr_i[`MMU_ADDR_W-1:`MMU_OFFSET_W], {`MMU_OFFSET_W{1'b0}}};
        end
        if (deliver_i) begin
            fill_q.line_addr <= line_addr_q;
            fill_q.way       <= way_i;
            fill_q.data      <= err_i ? '0 : data_i;
            fill_q.err       <= err_i;
        end
    end

    assign miss_ack_o  = ack_q;
    assign fill_o      = fill_q;
    assign pending_o   = pending_q;
    assign line_addr_o = line_addr_q;

endmodule : mmu_miss_buffer

// File: rtl/mmu_pkg.sv
`include "mmu_defs.svh"

package mmu_pkg;

    typedef logic [`MMU_ADDR_W-1:0] addr_t;
    typedef logic [`MMU_LINE_BYTES*8-1:0] line_t;
    typedef logic [`MMU_INDEX_W-1:0] index_t;
    typedef logic [`MMU_WAY_W-1:0] way_t;

    // One hit report from a cache, applied in the cycle it is valid
    typedef struct packed {
        logic   valid;
        index_t index;
        way_t   way;
    } hit_t;

    // Answer returned with a miss ack
    typedef struct packed {
        addr_t line_addr;
        way_t  way;
        line_t data;
        logic  err;
    } fill_t;

    typedef enum logic {
        DCACHE = 1'b0,
        ICACHE = 1'b1
    } src_e;

    typedef enum logic [2:0] {
        IDLE,
        MM_REQ,
        MM_WAIT,
        MM_RELEASE,
        DELIVER
    } mmu_state_e;

endpackage : mmu_pkg

// File: rtl/mmu_top.sv
`timescale 1ns/100ps

module mmu_top (
    input  logic           clk_i,
    input  logic           rst_n_i,
    // Data cache
    input  logic           dc_miss_req_i,
    input  mmu_pkg::addr_t dc_miss_addr_i,
    input  mmu_pkg::hit_t  dc_hit_i,
    output logic           dc_miss_ack_o,
    output mmu_pkg::fill_t dc_fill_o,
    // Instruction cache
    input  logic           ic_miss_req_i,
    input  mmu_pkg::addr_t ic_miss_addr_i,
    input  mmu_pkg::hit_t  ic_hit_i,
    output logic           ic_miss_ack_o,
    output mmu_pkg::fill_t ic_fill_o,
    // Main memory
    input  logic           mm_ack_i,
    input  mmu_pkg::line_t mm_data_i,
    output logic           mm_req_o,
    output mmu_pkg::addr_t mm_addr_o
);

    logic            dc_pending;
    logic            ic_pending;
    mmu_pkg::addr_t  dc_line_addr;
    mmu_pkg::addr_t  ic_line_addr;
    mmu_pkg::way_t   dc_victim;
    mmu_pkg::way_t   ic_victim;
    mmu_pkg::src_e   sel;
    logic            deliver_dc;
    logic            deliver_ic;
    logic            fill_err;
    logic            timer_start;
    logic            timer_clear;
    logic            timer_expired;
    logic            lru_fill;
    mmu_pkg::index_t lru_index;

    mmu_miss_buffer u_dc_buf (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .miss_req_i  (dc_miss_req_i),
        .miss_addr_i (dc_miss_addr_i),
        .deliver_i   (deliver_dc),
        .err_i       (fill_err),
        .data_i      (mm_data_i),
        .way_i       (dc_victim),
        .miss_ack_o  (dc_miss_ack_o),
        .fill_o      (dc_fill_o),
        .pending_o   (dc_pending),
        .line_addr_o (dc_line_addr)
    );

    mmu_miss_buffer u_ic_buf (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .miss_req_i  (ic_miss_req_i),
        .miss_addr_i (ic_miss_addr_i),
        .deliver_i   (deliver_ic),
        .err_i       (fill_err),
        .data_i      (mm_data_i),
        .way_i       (ic_victim),
        .miss_ack_o  (ic_miss_ack_o),
        .fill_o      (ic_fill_o),
        .pending_o   (ic_pending),
        .line_addr_o (ic_line_addr)
    );

    mmu_lru u_lru (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .dc_hit_i     (dc_hit_i),
        .ic_hit_i     (ic_hit_i),
        .fill_i       (lru_fill),
        .fill_src_i   (sel),
        .fill_index_i (lru_index),
        .dc_victim_o  (dc_victim),
        .ic_victim_o  (ic_victim)
    );

    mmu_wait_timer u_timer (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .start_i   (timer_start),
        .clear_i   (timer_clear),
        .expired_o (timer_expired)
    );

    mmu_fsm u_fsm (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .dc_pending_i  (dc_pending),
        .ic_pending_i  (ic_pending),
        .dc_addr_i     (dc_line_addr),
        .ic_addr_i     (ic_line_addr),
        .mm_ack_i      (mm_ack_i),
        .expired_i     (timer_expired),
        .mm_req_o      (mm_req_o),
        .mm_addr_o     (mm_addr_o),
        .sel_o         (sel),
        .deliver_dc_o  (deliver_dc),
        .deliver_ic_o  (deliver_ic),
        .err_o         (fill_err),
        .timer_start_o (timer_start),
        .timer_clear_o (timer_clear),
        .lru_fill_o    (lru_fill),
        .lru_index_o   (lru_index)
    );

endmodule : mmu_top

// File: rtl/mmu_wait_timer.sv
`timescale 1ns/100ps
`include "mmu_defs.svh"

module mmu_wait_timer (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic start_i,
    input  logic clear_i,
    output logic expired_o
);

    localparam int CNT_W = $clog2(`MMU_TIMEOUT + 1);

    logic             running_q;
    logic [CNT_W-1:0] count_q;
    logic             at_limit;

    assign at_limit = (count_q == CNT_W'(`MMU_TIMEOUT));

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            running_q <= 1'b0;
            count_q   <= '0;
        end else if (clear_i) begin
            running_q <= 1'b0;
        end else if (start_i) begin
            running_q <= 1'b1;
            count_q   <= '0;
        end else if (running_q && !at_limit) begin
            // Saturates at the limit until cleared
            count_q <= count_q + 1'b1;
        end
    end

    assign expired_o = running_q && at_limit;

endmodule : mmu_wait_timer

// File: run.sh
#!/bin/sh
# Build and run the MMU miss unit simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_mmu -f flist.f -o sim_mmu

./obj_dir/sim_mmu +verilator+error+limit+100 | tee sim.log

if grep -q "^Test completed successfully$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation FAILED, see sim.log"
    exit 1
fi

// File: test/mmu_asserts.sv
`timescale 1ns/100ps

module mmu_asserts (
    input logic                clk_i,
    input logic                rst_n_i,
    input logic                mm_req_i,
    input logic                mm_ack_i,
    input mmu_pkg::addr_t      mm_addr_i,
    input logic                dc_req_i,
    input logic                dc_ack_i,
    input logic                ic_req_i,
    input logic                ic_ack_i,
    input mmu_pkg::mmu_state_e state_i
);

    mm_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mm_req_i && $past(mm_req_i) |-> mm_addr_i == $past(mm_addr_i))
        else $error("mm_addr_o changed while mm_req_o was high");

    // A new memory request waits until the previous ack has fallen
    mm_req_after_release: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(mm_req_i) |-> !mm_ack_i)
        else $error("mm_req_o rose while mm_ack_i was still high");

    // The cache drops its req right after the ack edge
    dc_ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(dc_ack_i) |-> $past(dc_req_i))
        else $error("dc_miss_ack_o rose without dc_miss_req_i");

    ic_ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(ic_ack_i) |-> $past(ic_req_i))
        else $error("ic_miss_ack_o rose without ic_miss_req_i");

    idle_after_reset: assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> state_i == mmu_pkg::IDLE)
        else $error("FSM not idle after reset");

endmodule : mmu_asserts

bind mmu_top mmu_asserts u_asserts (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .mm_req_i (mm_req_o),
    .mm_ack_i (mm_ack_i),
    .mm_addr_i(mm_addr_o),
    .dc_req_i (dc_miss_req_i),
    .dc_ack_i (dc_miss_ack_o),
    .ic_req_i (ic_miss_req_i),
    .ic_ack_i (ic_miss_ack_o),
    .state_i  (u_fsm.state_q)
);

// File: test/mmu_checker.sv
`timescale 1ns/100ps
`include "mmu_defs.svh"

module mmu_checker (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           miss_req_i [2],
    input  mmu_pkg::addr_t miss_addr_i [2],
    input  mmu_pkg::hit_t  hit_i [2],
    input  logic           miss_ack_i [2],
    input  mmu_pkg::fill_t fill_i [2],
    input  logic           mm_req_i,
    input  mmu_pkg::addr_t mm_addr_i,
    input  logic           mm_ack_i,
    output int             error_count_o,
    output int             fill_count_o
);

    // Model recency per cache, set and way; 0 is least recent
    int             rank [2][`MMU_SETS][`MMU_WAYS];
    mmu_pkg::hit_t  hit_q [2];
    mmu_pkg::addr_t miss_addr_q [2];
    int             wait_age [2];
    int             late_ack [2];
    logic           ack_q [2];
    logic           mm_req_q;
    logic           mm_acked;
    logic           mm_aborted;
    int             mm_cycles;
    mmu_pkg::addr_t mm_addr_q;
    logic           exp_valid;
    int             exp_src;
    int             errors;
    int             fills;

    assign error_count_o = errors;
    assign fill_count_o  = fills;

    function automatic mmu_pkg::line_t line_hash(input mmu_pkg::addr_t a);
        return {a ^ 32'h9e37_79b9, a * 32'h0019_660d, ~a, a + 32'h7f4a_7c15};
    endfunction

    function automatic int model_victim(input int c, input int s);
        int v;
        v = 0;
        for (int w = 0; w < `MMU_WAYS; w++) begin
            if (rank[c][s][w] == 0) v = w;
        end
        return v;
    endfunction

    task automatic model_touch(input int c, input int s, input int w);
        for (int k = 0; k < `MMU_WAYS; k++) begin
            if (rank[c][s][k] > rank[c][s][w]) rank[c][s][k] = rank[c][s][k] - 1;
        end
        rank[c][s][w] = `MMU_WAYS - 1;
    endtask

    task automatic model_reset();
        for (int c = 0; c < 2; c++) begin
            for (int s = 0; s < `MMU_SETS; s++) begin
                for (int w = 0; w < `MMU_WAYS; w++) rank[c][s][w] = w;
            end
            hit_q[c]    = '0;
            wait_age[c] = 0;
            late_ack[c] = 0;
            ack_q[c]    = 1'b0;
        end
        mm_req_q   = 1'b0;
        mm_aborted = 1'b0;
        exp_valid  = 1'b0;
    endtask

    task automatic mismatch(input string name, input logic [127:0] exp_v,
                            input logic [127:0] got_v);
        $display("MISMATCH at %0t: %s expected %h got %h", $time, name, exp_v, got_v);
        errors++;
    endtask

    task automatic failure(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        errors++;
    endtask

    // Returns the way the model picks, to be marked most recent afterwards
    task automatic check_fill(input int c, output int set, output int way);
        mmu_pkg::fill_t f;
        mmu_pkg::addr_t line;
        mmu_pkg::line_t exp_data;
        f        = fill_i[c];
        line     = miss_addr_q[c] & ~32'(`MMU_LINE_BYTES - 1);
        set      = int'(line[`MMU_OFFSET_W +: `MMU_INDEX_W]);
        way      = model_victim(c, set);
        exp_data = mm_aborted ? '0 : line_hash(line);
        if (f.line_addr !== line) mismatch("fill.line_addr", 128'(line), 128'(f.line_addr));
        if (int'(f.way) != way) mismatch("fill.way", 128'(way), 128'(f.way));
        if (f.err !== mm_aborted) mismatch("fill.err", 128'(mm_aborted), 128'(f.err));
        if (f.data !== exp_data) mismatch("fill.data", exp_data, f.data);
        if (exp_valid && exp_src != c) failure("fill delivered to the wrong cache first");
        exp_valid = 1'b0;
        if (wait_age[1 - c] >= 3) begin
            exp_valid = 1'b1;
            exp_src   = 1 - c;
        end
        fills++;
    endtask

    initial begin
        errors = 0;
        fills  = 0;
        model_reset();
    end

    always @(negedge clk_i) begin
        int set;
        int way;
        if (!rst_n_i) begin
            if (miss_ack_i[0] || miss_ack_i[1] || mm_req_i) begin
                failure("ack or memory request high during reset");
            end
            model_reset();
        end else begin
            // Memory transaction tracking
            if (mm_req_i && !mm_req_q) begin
                if (mm_ack_i) failure("memory request raised while its ack was still high");
                mm_acked   = mm_ack_i;
                mm_aborted = 1'b0;
                mm_cycles  = 0;
                mm_addr_q  = mm_addr_i;
                if (!exp_valid && wait_age[0] >= 4) begin
                    exp_valid = 1'b1;
                    exp_src   = 0;
                end
            end else if (mm_req_i) begin
                if (mm_addr_i !== mm_addr_q) begin
                    mismatch("mm_addr_o", 128'(mm_addr_q), 128'(mm_addr_i));
                end
                if (!mm_acked) begin
                    if (mm_ack_i) mm_acked = 1'b1;
                    else mm_cycles++;
                end
            end else if (mm_req_q && !mm_acked) begin
                mm_aborted = 1'b1;
                if (mm_cycles < `MMU_TIMEOUT) failure("memory request aborted before the timeout");
            end
            mm_req_q = mm_req_i;

            // Capture new misses and age the waiting ones
            for (int c = 0; c < 2; c++) begin
                if (miss_req_i[c] && !miss_ack_i[c] && wait_age[c] == 0) begin
                    miss_addr_q[c] = miss_addr_i[c];
                end
                wait_age[c] = (miss_req_i[c] && !miss_ack_i[c]) ? wait_age[c] + 1 : 0;
            end

            for (int c = 0; c < 2; c++) begin
                if (miss_ack_i[c] && !ack_q[c]) begin
                    check_fill(c, set, way);
                    if (hit_q[c].valid) model_touch(c, int'(hit_q[c].index), int'(hit_q[c].way));
                    model_touch(c, set, way);
                end else if (hit_q[c].valid) begin
                    model_touch(c, int'(hit_q[c].index), int'(hit_q[c].way));
                end
                if (ack_q[c] && !miss_ack_i[c] && miss_req_i[c]) begin
                    failure("miss ack fell while its req was still high");
                end
                hit_q[c] = hit_i[c];
                late_ack[c] = (miss_ack_i[c] && !miss_req_i[c]) ? late_ack[c] + 1 : 0;
                if (late_ack[c] > 1) failure("miss ack stayed high after its req fell");
                ack_q[c] = miss_ack_i[c];
            end
        end
    end

endmodule : mmu_checker

// File: test/tb_mmu.sv
`timescale 1ns/100ps
`include "mmu_defs.svh"

module tb_mmu;

    localparam int MISSES    = 60;
    localparam int ACK_LIMIT = 300;

    logic           clk;
    logic           rst_n;
    logic           miss_req [2];
    mmu_pkg::addr_t miss_addr [2];
    mmu_pkg::hit_t  hit [2];
    logic           miss_ack [2];
    mmu_pkg::fill_t fill [2];
    logic           mm_req;
    mmu_pkg::addr_t mm_addr;
    logic           mm_ack;
    mmu_pkg::line_t mm_data;
    logic           mem_busy;
    int             mem_delay;
    int             error_count;
    int             fill_count;
    int             timeouts;

    mmu_top u_dut (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .dc_miss_req_i  (miss_req[0]),
        .dc_miss_addr_i (miss_addr[0]),
        .dc_hit_i       (hit[0]),
        .dc_miss_ack_o  (miss_ack[0]),
        .dc_fill_o      (fill[0]),
        .ic_miss_req_i  (miss_req[1]),
        .ic_miss_addr_i (miss_addr[1]),
        .ic_hit_i       (hit[1]),
        .ic_miss_ack_o  (miss_ack[1]),
        .ic_fill_o      (fill[1]),
        .mm_ack_i       (mm_ack),
        .mm_data_i      (mm_data),
        .mm_req_o       (mm_req),
        .mm_addr_o      (mm_addr)
    );

    mmu_checker u_chk (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .miss_req_i    (miss_req),
        .miss_addr_i   (miss_addr),
        .hit_i         (hit),
        .miss_ack_i    (miss_ack),
        .fill_i        (fill),
        .mm_req_i      (mm_req),
        .mm_addr_i     (mm_addr),
        .mm_ack_i      (mm_ack),
        .error_count_o (error_count),
        .fill_count_o  (fill_count)
    );

    always #2 clk = ~clk;

    function automatic mmu_pkg::line_t line_hash(input mmu_pkg::addr_t a);
        return {a ^ 32'h9e37_79b9, a * 32'h0019_660d, ~a, a + 32'h7f4a_7c15};
    endfunction

    function automatic mmu_pkg::hit_t random_hit();
        mmu_pkg::hit_t h;
        h.valid = ($urandom_range(0, 2) == 0);
        h.index = mmu_pkg::index_t'($urandom_range(0, `MMU_SETS - 1));
        h.way   = mmu_pkg::way_t'($urandom_range(0, `MMU_WAYS - 1));
        return h;
    endfunction

    task automatic report_timeout(input string msg);
        $display("Timeout: %s", msg);
        timeouts++;
    endtask

    // Small address space so sets and lines repeat
    task automatic cache_agent(input int c);
        int cycles;
        for (int i = 0; i < MISSES; i++) begin
            repeat ($urandom_range(1, 6)) @(posedge clk);
            #1;
            miss_addr[c] = 32'h8000_0000 | ($urandom & 32'h0000_03ff);
            miss_req[c]  = 1'b1;
            cycles = 0;
            while (!miss_ack[c]) begin
                @(posedge clk);
                #1;
                cycles++;
                if (cycles > ACK_LIMIT) begin
                    report_timeout($sformatf("miss ack of cache %0d never rose", c));
                    return;
                end
            end
            miss_req[c] = 1'b0;
            cycles = 0;
            while (miss_ack[c]) begin
                @(posedge clk);
                #1;
                cycles++;
                if (cycles > ACK_LIMIT) begin
                    report_timeout($sformatf("miss ack of cache %0d never fell", c));
                    return;
                end
            end
        end
    endtask

    always @(posedge clk) begin
        #1;
        hit[0] = random_hit();
        hit[1] = random_hit();
    end

    // Main memory with a random latency; a late answer is dropped by the abort
    always @(posedge clk) begin
        #1;
        if (!rst_n) begin
            mm_ack   = 1'b0;
            mem_busy = 1'b0;
        end else if (!mem_busy) begin
            if (mm_req) begin
                mem_busy  = 1'b1;
                mem_delay = $urandom_range(1, 30);
            end
        end else if (!mm_ack) begin
            if (!mm_req) begin
                mem_busy = 1'b0;
            end else if (mem_delay <= 1) begin
                mm_ack  = 1'b1;
                mm_data = line_hash(mm_addr);
            end else begin
                mem_delay--;
            end
        end else if (!mm_req) begin
            mm_ack   = 1'b0;
            mem_busy = 1'b0;
        end
    end

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        miss_req  = '{1'b0, 1'b0};
        miss_addr = '{32'h0, 32'h0};
        hit       = '{'0, '0};
        mm_ack    = 1'b0;
        mm_data   = '0;
        mem_busy  = 1'b0;
        mem_delay = 0;
        timeouts  = 0;
        void'($urandom(32'h0e07_ee49));
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        fork
            cache_agent(0);
            cache_agent(1);
        join
        repeat (10) @(posedge clk);
        if (fill_count != 2 * MISSES) begin
            $display("Only %0d of %0d misses produced a fill", fill_count, 2 * MISSES);
        end
        $display("Fills checked: %0d, errors: %0d, timeouts: %0d",
                 fill_count, error_count, timeouts);
        if (error_count == 0 && timeouts == 0 && fill_count == 2 * MISSES) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : tb_mmu
